//--- Makefile
SRCS = mul_pkg.sv booth_encoder.sv wallace.sv mul_final_add.sv mul_ctrl.sv mul_top.sv tb_mul.sv

.PHONY: all run clean

all: run

obj_dir/Vtb_mul: $(SRCS) sim.f
	verilator --binary --timing --assert --top-module tb_mul -Mdir obj_dir -f sim.f

run: obj_dir/Vtb_mul
	./obj_dir/Vtb_mul | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- booth_encoder.sv
module booth_encoder
    import mul_pkg::*;
(
    input  mul_req_t req,
    output pp_t      pp [pp_count]
);

    logic                   a_signed;
    logic                   b_signed;
    logic [sword_width-1:0] a;
    logic [sword_width-1:0] b;
    logic [sword_width+1:0] b_ext;
    pp_t                    a_x1;
    pp_t                    a_x2;

    // rs1 is the multiplicand, rs2 the multiplier
    always_comb begin
        a_signed = (req.op == mulh) || (req.op == mulhsu);
        b_signed = (req.op == mulh);
        a = {a_signed & req.rs1[word_width-1], req.rs1};
        b = {b_signed & req.rs2[word_width-1], req.rs2};
    end

    // one sign bit on top, implicit zero below bit 0
    assign b_ext = {b[sword_width-1], b, 1'b0};

    assign a_x1 = {{(pp_width - sword_width){a[sword_width-1]}}, a};
    assign a_x2 = a_x1 << 1;

    for (genvar i = 0; i < pp_count; i++) begin : g_pp
        logic [2:0] trip;
        pp_t        mag;

        assign trip = b_ext[2*i+2 -: 3];

        always_comb begin
            case (trip)
                3'b001, 3'b010: begin
                    mag = a_x1;
                end
                3'b011: begin
                    mag = a_x2;
                end
                3'b100: begin
                    mag = -a_x2;
                end
                3'b101, 3'b110: begin
                    mag = -a_x1;
                end
                default: begin
                    mag = '0;
                end
            endcase
        end

        // weight of triplet i is 4**i
        assign pp[i] = mag << (2 * i);
    end

    // op comes from the capture register in the controller
    always_comb begin
        assert (!$isunknown(req.op))
        else $error("booth_encoder: unknown op %b", req.op);
    end

endmodule

//--- mul_ctrl.sv
module mul_ctrl
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req,
    input  mul_req_t req_data,
    output logic     ack,
    output mul_req_t cap_req,
    output logic     row_en,
    output logic     res_en
);

    typedef enum logic [1:0] {
        s_idle,
        s_tree,
        s_add,
        s_done
    } state_t;

    state_t state;
    logic   accept;

    // ack is low whenever the FSM is idle
    assign accept = (state == s_idle) && req;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
            ack   <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (accept) begin
                        state <= s_tree;
                    end
                end
                s_tree: begin
                    state <= s_add;
                end
                s_add: begin
                    state <= s_done;
                end
                s_done: begin
                    // raise ack one edge after the result lands
                    if (!ack) begin
                        ack <= 1'b1;
                    end else if (!req) begin
                        ack   <= 1'b0;
                        state <= s_idle;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cap_req <= req_data;
        end
    end

    assign row_en = (state == s_tree);
    assign res_en = (state == s_add);

    assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
    else $error("mul_ctrl: ack rose without req");

    // requester must hold operands until ack
    assert property (@(posedge clk) disable iff (rst)
        (req && !ack) ##1 (req && !ack) |-> $stable(req_data))
    else $error("mul_ctrl: req_data changed while waiting for ack");

endmodule

//--- mul_final_add.sv
module mul_final_add
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     row_en,
    input  logic     res_en,
    input  mul_op_t  op,
    input  csa_row_t rows,
    output word_t    result
);

    csa_row_t rows_q;
    pp_t      prod;

    // tree output register
    always_ff @(posedge clk) begin
        if (row_en) begin
            rows_q <= rows;
        end
    end

    assign prod = rows_q.sum + rows_q.carry;

    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else if (res_en) begin
            if (op == mul) begin
                result <= prod[word_width-1:0];
            end else begin
                // high word for mulh, mulhsu and mulhu
                result <= prod[2*word_width-1:word_width];
            end
        end
    end

    // tree and adder stages are one cycle apart
    assert property (@(posedge clk) disable iff (rst) !(row_en && res_en))
    else $error("mul_final_add: row_en and res_en high together");

endmodule

//--- mul_pkg.sv
package mul_pkg;

    localparam int word_width  = 32;
    // one extra bit so unsigned operands fit a signed multiply
    localparam int sword_width = word_width + 1;
    localparam int pp_width    = 2 * sword_width;
    localparam int pp_count    = 17;

    typedef logic [word_width-1:0] word_t;
    typedef logic [pp_width-1:0]   pp_t;

    // same order as funct3 of the M extension
    typedef enum logic [1:0] {
        mul,
        mulh,
        mulhsu,
        mulhu
    } mul_op_t;

    typedef struct packed {
        mul_op_t op;
        word_t   rs1;
        word_t   rs2;
    } mul_req_t;

    typedef struct packed {
        pp_t sum;
        pp_t carry;
    } csa_row_t;

    // 3:2 carry-save compressor over whole rows
    function automatic csa_row_t csa_3to2(input pp_t a, input pp_t b, input pp_t c);
        csa_row_t r;
        r.sum   = a ^ b ^ c;
        // carry out of the top bit drops, all sums are mod 2**pp_width
        r.carry = ((a & b) | (a & c) | (b & c)) << 1;
        return r;
    endfunction

endpackage

//--- mul_top.sv
module mul_top
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req,
    input  mul_req_t req_data,
    output logic     ack,
    output word_t    result
);

    mul_req_t cap_req;
    logic     row_en;
    logic     res_en;
    pp_t      pp [pp_count];
    csa_row_t rows;

    mul_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .cap_req  (cap_req),
        .row_en   (row_en),
        .res_en   (res_en)
    );

    booth_encoder u_booth (
        .req (cap_req),
        .pp  (pp)
    );

    wallace u_wallace (
        .pp   (pp),
        .rows (rows)
    );

    // op stays in cap_req until the next accept
    mul_final_add u_final_add (
        .clk    (clk),
        .rst    (rst),
        .row_en (row_en),
        .res_en (res_en),
        .op     (cap_req.op),
        .rows   (rows),
        .result (result)
    );

endmodule

//--- sim.f
mul_pkg.sv
booth_encoder.sv
wallace.sv
mul_final_add.sv
mul_ctrl.sv
mul_top.sv
tb_mul.sv

//--- tb_mul.sv
module tb_mul
    import mul_pkg::*;
;

    localparam int n_random = 200;
    // 1 handshake + 6 mul + 5 mulh + 10 mulhsu/mulhu + random
    localparam int n_trans = 22 + n_random;
    localparam int watchdog_time = (n_trans * 10 + 100) * 20;

    logic     clk;
    logic     rst;
    logic     req;
    mul_req_t req_data;
    logic     ack;
    word_t    result;

    word_t    rng_state;

    mul_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", why);
    endtask

    initial begin
        #(watchdog_time);
        $display("timeout at %0t, the DUT never finished a handshake", $time);
        abort_run("simulation stopped by the watchdog");
    end

    function automatic word_t next_rand(input word_t s);
        word_t x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // 64-bit signed product of the extended operands
    function automatic word_t ref_mul(input mul_op_t op, input word_t a, input word_t b);
        logic   a_sgn;
        logic   b_sgn;
        longint sa;
        longint sb;
        longint p;
        a_sgn = (op == mulh) || (op == mulhsu);
        b_sgn = (op == mulh);
        sa = {{32{a_sgn & a[31]}}, a};
        sb = {{32{b_sgn & b[31]}}, b};
        // mulhu overflows into bit 64 but bits 63..0 still hold
        p = sa * sb;
        if (op == mul) begin
            return p[31:0];
        end
        return p[63:32];
    endfunction

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error: time %0t: %s got %h expected %h", $time, what, got, exp);
            abort_run("result mismatch");
        end
    endtask

    task automatic check_ack(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: time %0t: %s ack is %b expected %b", $time, what, got, exp);
            abort_run("handshake mismatch");
        end
    endtask

    // full four-phase exchange that returns with ack low again
    task automatic do_mul(input mul_op_t op, input word_t a, input word_t b,
                          output word_t res);
        @(posedge clk);
        req_data.op  <= op;
        req_data.rs1 <= a;
        req_data.rs2 <= b;
        req          <= 1'b1;
        @(negedge clk);
        while (ack !== 1'b1) begin
            @(negedge clk);
        end
        res = result;
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        while (ack !== 1'b0) begin
            @(negedge clk);
        end
    endtask

    task automatic run_case(input string what, input mul_op_t op, input word_t a,
                            input word_t b, input word_t exp);
        word_t got;
        do_mul(op, a, b, got);
        check_word(what, got, exp);
    endtask

    task automatic handshake_timing();
        word_t held;
        check_ack("after reset", ack, 1'b0);
        check_word("result after reset", result, '0);
        @(posedge clk);
        req_data.op  <= mul;
        req_data.rs1 <= 32'd1234;
        req_data.rs2 <= 32'd5678;
        req          <= 1'b1;
        // edge 0 is the next rising edge and ack rises at edge 3
        repeat (4) begin
            @(negedge clk);
            check_ack("before edge 3", ack, 1'b0);
        end
        @(negedge clk);
        check_ack("after edge 3", ack, 1'b1);
        check_word("mul 1234 * 5678", result, 32'd7006652);
        held = result;
        repeat (10) begin
            @(negedge clk);
            check_ack("req still high", ack, 1'b1);
            check_word("result held", result, held);
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        check_ack("req low not yet sampled", ack, 1'b1);
        @(negedge clk);
        check_ack("req low sampled", ack, 1'b0);
    endtask

    task automatic mul_corners();
        run_case("mul zero", mul, 32'h0000_0000, 32'h1234_5678, 32'h0000_0000);
        run_case("mul one", mul, 32'h0000_0001, 32'hDEAD_BEEF, 32'hDEAD_BEEF);
        run_case("mul all ones squared", mul, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001);
        run_case("mul min times two", mul, 32'h8000_0000, 32'h0000_0002, 32'h0000_0000);
        run_case("mul 5555 squared", mul, 32'h5555_5555, 32'h5555_5555, 32'h38E3_8E39);
        run_case("mul aaaa * 5555", mul, 32'hAAAA_AAAA, 32'h5555_5555, 32'h71C7_1C72);
    endtask

    task automatic mulh_corners();
        run_case("mulh min squared", mulh, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
        run_case("mulh -1 * -1", mulh, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000);
        run_case("mulh min * -1", mulh, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
        run_case("mulh max squared", mulh, 32'h7FFF_FFFF, 32'h7FFF_FFFF, 32'h3FFF_FFFF);
        run_case("mulh -1 * 1", mulh, 32'hFFFF_FFFF, 32'h0000_0001, 32'hFFFF_FFFF);
    endtask

    // same pairs as mulh with rs2 unsigned (and rs1 too for mulhu)
    task automatic high_word_variants();
        run_case("mulhsu min, 2^31", mulhsu, 32'h8000_0000, 32'h8000_0000, 32'hC000_0000);
        run_case("mulhsu -1, ffffffff", mulhsu, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        run_case("mulhsu min, ffffffff", mulhsu, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
        run_case("mulhsu max squared", mulhsu, 32'h7FFF_FFFF, 32'h7FFF_FFFF, 32'h3FFF_FFFF);
        run_case("mulhsu -1, 1", mulhsu, 32'hFFFF_FFFF, 32'h0000_0001, 32'hFFFF_FFFF);
        run_case("mulhu 2^31 squared", mulhu, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
        run_case("mulhu ffffffff squared", mulhu, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE);
        run_case("mulhu 2^31, ffffffff", mulhu, 32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF);
        run_case("mulhu max squared", mulhu, 32'h7FFF_FFFF, 32'h7FFF_FFFF, 32'h3FFF_FFFF);
        run_case("mulhu ffffffff, 1", mulhu, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000);
    endtask

    task automatic random_traffic();
        word_t   a;
        word_t   b;
        word_t   r;
        word_t   exp;
        mul_op_t op;
        for (int i = 0; i < n_random; i++) begin
            rng_state = next_rand(rng_state);
            a = rng_state;
            rng_state = next_rand(rng_state);
            b = rng_state;
            rng_state = next_rand(rng_state);
            r = rng_state;
            op = mul_op_t'(r[1:0]);
            exp = ref_mul(op, a, b);
            run_case($sformatf("random %0d %s %h %h", i, op.name(), a, b), op, a, b, exp);
            // idle gap of 0 to 3 cycles
            repeat (r[3:2]) @(posedge clk);
        end
    endtask

    initial begin
        rst       = 1'b1;
        req       = 1'b0;
        req_data  = '0;
        rng_state = 32'd81;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        handshake_timing();
        mul_corners();
        mulh_corners();
        high_word_variants();
        random_traffic();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- wallace.sv
module wallace
    import mul_pkg::*;
(
    input  pp_t      pp [pp_count],
    output csa_row_t rows
);

    csa_row_t c [15];

    // stage 1, rows 0..14 in groups of three
    for (genvar i = 0; i < 5; i++) begin : g_stage1
        assign c[i] = csa_3to2(pp[3*i], pp[3*i+1], pp[3*i+2]);
    end

    // stage 2, last two pp rows join here
    assign c[5] = csa_3to2(c[0].sum, c[0].carry, c[1].sum);
    assign c[6] = csa_3to2(c[1].carry, c[2].sum, c[2].carry);
    assign c[7] = csa_3to2(c[3].sum, c[3].carry, c[4].sum);
    assign c[8] = csa_3to2(c[4].carry, pp[15], pp[16]);

    // stage 3
    assign c[9]  = csa_3to2(c[5].sum, c[5].carry, c[6].sum);
    assign c[10] = csa_3to2(c[6].carry, c[7].sum, c[7].carry);

    // stage 4
    assign c[11] = csa_3to2(c[9].sum, c[9].carry, c[10].sum);
    assign c[12] = csa_3to2(c[10].carry, c[8].sum, c[8].carry);

    // stage 5
    assign c[13] = csa_3to2(c[11].sum, c[11].carry, c[12].sum);

    // stage 6, carry of c12 waited two levels
    assign c[14] = csa_3to2(c[13].sum, c[13].carry, c[12].carry);

    assign rows = c[14];

endmodule
